//--- files.f
verilog/ossc_pkg.sv
verilog/reset_stretch.sv
verilog/input_sync.sv
verilog/sys_ctrl_regs.sv
verilog/source_select.sv
verilog/activity_led.sv
verilog/ossc_top.sv
tb/ossc_regs_chk.sv
tb/tb_ossc_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0 -Wno-fatal
TOP       := tb_ossc_top
FILELIST  := files.f
OBJ_DIR   := obj_dir

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

# status comes from the pass line in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/ossc_stimulus.txt
# op f1 f2 f3 f4 f5, fields in hex, unused fields are 0
# w adr wdata exp_read exp_pins(audmux,hdmirx,isl) | i btn ir exp_status | a cap aud pcm hdmi exp
# v capture_sel sample_count | l second_pulse_gap (0 for a single pulse)
w 0 00000003 00000003 3 0
w 0 0000000a 0000000a 6 0
w 0 00000005 00000005 1 0
w 0 00000000 00000000 0 0
w 1 12345678 0000000f 0 0
w 2 ffffffff 00000000 0 0
w 3 a5a5a5a5 00000000 0 0
w 0 00000003 00000003 3 0
i 0 1 0000000c 0 0
i 1 0 00000009 0 0
i 2 1 0000000e 0 0
i 3 1 0000000f 0 0
a 0 0 5 2 5
a 0 1 5 2 2
a 1 0 3 4 4
a 1 1 6 1 1
v 0 40 0 0 0
v 1 40 0 0 0
l 0 0 0 0 0
l 14 0 0 0 0

//--- tb/tb_ossc_top.sv
module tb_ossc_top;
    import ossc_pkg::*;

    localparam int unsigned LED_HOLD = 40;
    // bound for any single wait, in clk27 cycles
    localparam int WAIT_LIMIT = 200;

    logic       clk27;
    logic       po_reset_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    video_bus_t isl_video, hdmirx_video, cap_video;
    i2s_t       pcm_i2s, hdmirx_i2s, tx_i2s;
    logic [1:0] btn;
    logic       ir_rx, resync_strobe;
    logic       isl_reset_n, hdmirx_reset_n, audmux, led_resync;

    int errors = 0;
    int tests = 0;
    int failed = 0;
    int seed = 79500;

    ossc_top #(
        .LED_HOLD (LED_HOLD)
    ) i_ossc_top (
        .clk27            (clk27),
        .po_reset_n       (po_reset_n),
        .wb_req_i         (wb_req),
        .wb_rsp_o         (wb_rsp),
        .isl_video_i      (isl_video),
        .hdmirx_video_i   (hdmirx_video),
        .pcm_i2s_i        (pcm_i2s),
        .hdmirx_i2s_i     (hdmirx_i2s),
        .btn_i            (btn),
        .ir_rx_i          (ir_rx),
        .resync_strobe_i  (resync_strobe),
        .cap_video_o      (cap_video),
        .tx_i2s_o         (tx_i2s),
        .isl_reset_n_o    (isl_reset_n),
        .hdmirx_reset_n_o (hdmirx_reset_n),
        .audmux_o         (audmux),
        .led_resync_o     (led_resync)
    );

    always #2 clk27 = ~clk27;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error %s: got %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic close_test(input string tag, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, tag);
        end else begin
            failed++;
            $display("test %0d %s: mismatch", tests, tag);
        end
    endtask

    // one classic cycle, started and ended on falling edges
    task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        n = 0;
        rdat = '0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk27);
        while (!wb_rsp.ack && n < WAIT_LIMIT) begin
            @(negedge clk27);
            n++;
        end
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;
        end else begin
            report_problem("wishbone access got no ack in time");
        end
        wb_req = '0;
        // one idle cycle before the next request
        @(negedge clk27);
    endtask

    // pins driven by the control word, audmux in the top bit
    function automatic logic [2:0] ctrl_pins();
        return {audmux, hdmirx_reset_n, isl_reset_n};
    endfunction

    // random samples on both inputs, expected output trails by two edges
    task automatic video_test(input logic capsel, input int count);
        video_bus_t  pipe[$];
        video_bus_t  exp;
        logic [31:0] rnd_isl, rnd_hdmi, rd;
        int          k;
        wb_access(1'b1, REG_CTRL, {28'h0, 1'b0, capsel, 2'b11}, rd);
        for (k = 0; k < count + 2; k++) begin
            if (pipe.size() == 2) begin
                exp = pipe.pop_front();
                if (cap_video !== exp) begin
                    report_mismatch("cap_video_o", 32'(cap_video), 32'(exp));
                end
            end
            rnd_isl = $random(seed);
            rnd_hdmi = $random(seed);
            isl_video = rnd_isl[27:0];
            hdmirx_video = rnd_hdmi[27:0];
            pipe.push_back(capsel ? hdmirx_video : isl_video);
            @(negedge clk27);
        end
    endtask

    // one strobe pulse, and a second one gap cycles later when gap is nonzero
    task automatic led_test(input int gap);
        int t;
        int lit;
        logic seen, done;
        t = 0;
        lit = 0;
        seen = 1'b0;
        done = 1'b0;
        while (!done && t < 2 * LED_HOLD + gap + WAIT_LIMIT) begin
            resync_strobe = (t == 0) || (gap != 0 && t == gap);
            @(negedge clk27);
            t++;
            if (led_resync) begin
                seen = 1'b1;
                lit++;
            end else if (seen) begin
                done = 1'b1;
            end
        end
        resync_strobe = 1'b0;
        if (!seen) begin
            report_problem("led_resync_o never turned on");
        end else if (!done) begin
            report_problem("led_resync_o did not turn off in time");
        end else if (lit != LED_HOLD + gap) begin
            report_mismatch("led_resync_o lit cycles", lit, LED_HOLD + gap);
        end
    endtask

    initial begin
        int          fd, n, err0;
        string       text;
        byte         op;
        logic [31:0] f1, f2, f3, f4, f5, rd;

        clk27 = 1'b0;
        po_reset_n = 1'b0;
        wb_req = '0;
        // both video sources active while reset is held
        isl_video = video_bus_t'(28'h5a5a5a5);
        hdmirx_video = video_bus_t'(28'ha5a5a5a);
        pcm_i2s = '0;
        hdmirx_i2s = '0;
        // buttons and ir idle high
        btn = 2'b11;
        ir_rx = 1'b1;
        resync_strobe = 1'b0;

        repeat (8) @(negedge clk27);
        po_reset_n = 1'b1;
        n = 0;
        while (!i_ossc_top.sys_reset_n && n < WAIT_LIMIT) begin
            @(negedge clk27);
            n++;
        end
        if (!i_ossc_top.sys_reset_n) begin
            report_problem("system reset was not released in time");
        end

        // state right after reset
        // the active video inputs have not yet reached the capture output here
        err0 = errors;
        if (cap_video !== '0) report_mismatch("cap_video_o", 32'(cap_video), 32'h0);
        if (led_resync !== 1'b0) report_mismatch("led_resync_o", 32'(led_resync), 32'h0);
        if (ctrl_pins() !== 3'b000) report_mismatch("ctrl pins", 32'(ctrl_pins()), 32'h0);
        wb_access(1'b0, REG_CTRL, 32'h0, rd);
        if (rd !== 32'h0) report_mismatch("ctrl readback", rd, 32'h0);
        close_test("reset", err0);

        fd = $fopen("tb/ossc_stimulus.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open tb/ossc_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                if (text.len() < 2 || text[0] == "#") continue;
                err0 = errors;
                n = $sscanf(text, "%c %h %h %h %h %h", op, f1, f2, f3, f4, f5);
                if (n != 6) begin
                    report_problem("malformed stimulus line");
                end else if (op == "w") begin
                    wb_access(1'b1, f1[1:0], f2, rd);
                    if (ctrl_pins() !== f4[2:0]) begin
                        report_mismatch("ctrl pins", 32'(ctrl_pins()), f4);
                    end
                    wb_access(1'b0, f1[1:0], 32'h0, rd);
                    if (rd !== f3) report_mismatch("readback", rd, f3);
                end else if (op == "i") begin
                    btn = f1[1:0];
                    ir_rx = f2[0];
                    // two synchronizer edges plus margin
                    repeat (3) @(negedge clk27);
                    wb_access(1'b0, REG_STATUS, 32'h0, rd);
                    if (rd !== f3) report_mismatch("status", rd, f3);
                end else if (op == "a") begin
                    wb_access(1'b1, REG_CTRL, {28'h0, f2[0], f1[0], 2'b11}, rd);
                    pcm_i2s = f3[2:0];
                    hdmirx_i2s = f4[2:0];
                    @(negedge clk27);
                    if (tx_i2s !== f5[2:0]) report_mismatch("tx_i2s_o", 32'(tx_i2s), f5);
                end else if (op == "v") begin
                    video_test(f1[0], f2);
                end else if (op == "l") begin
                    led_test(f1);
                end else begin
                    report_problem("unknown stimulus record");
                end
                close_test($sformatf("%c", op), err0);
            end
            $fclose(fd);
        end

        errors += i_ossc_top.u_sys_ctrl_regs.i_regs_chk.fail_count;
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb/ossc_regs_chk.sv
module ossc_regs_chk (
    input logic              clk27,
    input logic              sys_reset_n,
    input ossc_pkg::wb_req_t wb_req_i,
    input ossc_pkg::wb_rsp_t wb_rsp_i
);

    // number of assertion failures so far
    int unsigned fail_count = 0;

    // an ack needs cyc and stb on the edge before it
    ack_after_req: assert property (@(posedge clk27) disable iff (!sys_reset_n)
        wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else begin
            fail_count++;
            $error("ack without a request on the previous edge");
        end

    // single cycle ack
    ack_one_cycle: assert property (@(posedge clk27) disable iff (!sys_reset_n)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack held for more than one cycle");
        end

    // no ack while in reset
    ack_quiet_in_reset: assert property (@(posedge clk27) !sys_reset_n |-> !wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack high during reset");
        end

endmodule

bind sys_ctrl_regs ossc_regs_chk i_regs_chk (
    .clk27       (clk27),
    .sys_reset_n (sys_reset_n),
    .wb_req_i    (wb_req_i),
    .wb_rsp_i    (wb_rsp_o)
);

//--- verilog/ossc_top.sv
module ossc_top #(
    parameter int unsigned LED_HOLD = ossc_pkg::LED_HOLD_DEFAULT
) (
    input  logic                 clk27,
    input  logic                 po_reset_n,

    // control bus from the external master
    input  ossc_pkg::wb_req_t    wb_req_i,
    output ossc_pkg::wb_rsp_t    wb_rsp_o,

    // video and audio sources
    input  ossc_pkg::video_bus_t isl_video_i,
    input  ossc_pkg::video_bus_t hdmirx_video_i,
    input  ossc_pkg::i2s_t       pcm_i2s_i,
    input  ossc_pkg::i2s_t       hdmirx_i2s_i,

    // asynchronous board inputs
    input  logic [1:0]           btn_i,
    input  logic                 ir_rx_i,
    input  logic                 resync_strobe_i,

    output ossc_pkg::video_bus_t cap_video_o,
    output ossc_pkg::i2s_t       tx_i2s_o,
    output logic                 isl_reset_n_o,
    output logic                 hdmirx_reset_n_o,
    output logic                 audmux_o,
    output logic                 led_resync_o
);
    import ossc_pkg::*;

    logic       sys_reset_n;
    logic [1:0] btn_sync;
    logic       ir_rx_sync;
    sys_ctrl_t  ctrl;

    // stretched system reset for everything below
    reset_stretch u_reset_stretch (
        .clk27         (clk27),
        .po_reset_n    (po_reset_n),
        .sys_reset_n_o (sys_reset_n)
    );

    // front panel buttons and ir receiver
    input_sync u_input_sync (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .btn_i       (btn_i),
        .ir_rx_i     (ir_rx_i),
        .btn_o       (btn_sync),
        .ir_rx_o     (ir_rx_sync)
    );

    // control and status registers
    sys_ctrl_regs u_sys_ctrl_regs (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .btn_i       (btn_sync),
        .ir_rx_i     (ir_rx_sync),
        .ctrl_o      (ctrl)
    );

    // capture video and audio routing
    source_select u_source_select (
        .clk27          (clk27),
        .sys_reset_n    (sys_reset_n),
        .capture_sel_i  (ctrl.capture_sel),
        .audmux_sel_i   (ctrl.audmux_sel),
        .isl_video_i    (isl_video_i),
        .hdmirx_video_i (hdmirx_video_i),
        .cap_video_o    (cap_video_o),
        .pcm_i2s_i      (pcm_i2s_i),
        .hdmirx_i2s_i   (hdmirx_i2s_i),
        .tx_i2s_o       (tx_i2s_o)
    );

    // resync activity indicator
    activity_led #(
        .LED_HOLD (LED_HOLD)
    ) u_activity_led (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .led_o           (led_resync_o)
    );

    // chip resets and audio mux straight from the control word
    assign isl_reset_n_o    = ctrl.isl_reset_n;
    assign hdmirx_reset_n_o = ctrl.hdmirx_reset_n;
    assign audmux_o         = ctrl.audmux_sel;

endmodule

//--- verilog/activity_led.sv
module activity_led #(
    parameter int unsigned LED_HOLD = ossc_pkg::LED_HOLD_DEFAULT
) (
    input  logic clk27,
    input  logic sys_reset_n,
    input  logic resync_strobe_i,
    output logic led_o
);

    // counter sized for the hold length
    localparam int unsigned CNT_W = $clog2(LED_HOLD + 1);
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(LED_HOLD);

    logic             sync1_q;
    logic             sync2_q;
    logic             prev_q;
    logic             strobe_rise;
    logic [CNT_W-1:0] cnt_q;

    // rising edge of the synchronized strobe
    assign strobe_rise = sync2_q & ~prev_q;

    // two flop synchronizer, third flop keeps the previous level
    // a new edge reloads the count even while the led is lit
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
            prev_q  <= 1'b0;
            cnt_q   <= '0;
        end else begin
            sync1_q <= resync_strobe_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            if (strobe_rise) begin
                cnt_q <= CNT_LOAD;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // lit for exactly LED_HOLD cycles after the last edge
    assign led_o = (cnt_q != '0);

endmodule

//--- verilog/source_select.sv
module source_select (
    input  logic                 clk27,
    input  logic                 sys_reset_n,
    input  logic                 capture_sel_i,
    input  logic                 audmux_sel_i,
    input  ossc_pkg::video_bus_t isl_video_i,
    input  ossc_pkg::video_bus_t hdmirx_video_i,
    output ossc_pkg::video_bus_t cap_video_o,
    input  ossc_pkg::i2s_t       pcm_i2s_i,
    input  ossc_pkg::i2s_t       hdmirx_i2s_i,
    output ossc_pkg::i2s_t       tx_i2s_o
);
    import ossc_pkg::*;

    video_bus_t isl_q;
    video_bus_t hdmirx_q;
    video_bus_t cap_q;

    // first stage registers both sources at the pins
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            isl_q    <= '0;
            hdmirx_q <= '0;
        end else begin
            isl_q    <= isl_video_i;
            hdmirx_q <= hdmirx_video_i;
        end
    end

    // second stage picks the capture source
    // 0 is the analog digitizer, 1 the hdmi receiver
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            cap_q <= '0;
        end else begin
            cap_q <= capture_sel_i ? hdmirx_q : isl_q;
        end
    end

    assign cap_video_o = cap_q;

    // hdmi audio follows hdmi capture and can also be forced by audmux
    // otherwise the pcm codec feeds the transmitter
    assign tx_i2s_o = (audmux_sel_i | capture_sel_i) ? hdmirx_i2s_i : pcm_i2s_i;

endmodule

//--- verilog/sys_ctrl_regs.sv
module sys_ctrl_regs (
    input  logic                clk27,
    input  logic                sys_reset_n,
    input  ossc_pkg::wb_req_t   wb_req_i,
    output ossc_pkg::wb_rsp_t   wb_rsp_o,
    input  logic [1:0]          btn_i,
    input  logic                ir_rx_i,
    output ossc_pkg::sys_ctrl_t ctrl_o
);
    import ossc_pkg::*;

    sys_ctrl_t             ctrl_q;
    sys_status_t           status;
    logic                  ack_q;
    logic [WB_DATA_W-1:0]  rdat_q;
    logic                  req_valid;
    logic                  ctrl_wr;
    reg_addr_e             addr;

    // unmapped word addresses keep their raw value here
    assign addr = reg_addr_e'(wb_req_i.adr);

    // new request only while no ack is pending
    // master drops stb after ack so this gives one ack per request
    assign req_valid = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

    // only the control register is writable
    assign ctrl_wr = req_valid & wb_req_i.we & (addr == REG_CTRL);

    // status word from synchronized inputs
    // ready reads as 1 on every access the slave can answer
    always_comb begin
        status           = '0;
        status.btn       = btn_i;
        status.ir_rx     = ir_rx_i;
        status.sys_ready = 1'b1;
    end

    // ack and control word
    // reset value holds both external chips in reset and selects the digitizer
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            ack_q  <= 1'b0;
            ctrl_q <= '0;
        end else begin
            ack_q <= req_valid;
            if (ctrl_wr) begin
                ctrl_q <= sys_ctrl_t'(wb_req_i.dat);
            end
        end
    end

    // read data captured together with ack
    // master only looks at it while ack is high
    always_ff @(posedge clk27) begin
        if (req_valid) begin
            case (addr)
                REG_CTRL:   rdat_q <= ctrl_q;
                REG_STATUS: rdat_q <= status;
                default:    rdat_q <= '0;
            endcase
        end
    end

    always_comb begin
        wb_rsp_o     = '0;
        wb_rsp_o.ack = ack_q;
        wb_rsp_o.dat = rdat_q;
    end

    assign ctrl_o = ctrl_q;

endmodule

//--- verilog/input_sync.sv
module input_sync (
    input  logic       clk27,
    input  logic       sys_reset_n,
    input  logic [1:0] btn_i,
    input  logic       ir_rx_i,
    output logic [1:0] btn_o,
    output logic       ir_rx_o
);

    // buttons and ir receiver share one three bit synchronizer
    // bit 2 is ir, bits 1:0 are the buttons
    logic [2:0] async_in;
    logic [2:0] sync1_q;
    logic [2:0] sync2_q;

    assign async_in = {ir_rx_i, btn_i};

    // inputs idle high so both stages reset to 1
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            sync1_q <= 3'b111;
            sync2_q <= 3'b111;
        end else begin
            // first stage may go metastable
            sync1_q <= async_in;
            sync2_q <= sync1_q;
        end
    end

    assign btn_o   = sync2_q[1:0];
    assign ir_rx_o = sync2_q[2];

endmodule

//--- verilog/reset_stretch.sv
module reset_stretch (
    input  logic clk27,
    input  logic po_reset_n,
    output logic sys_reset_n_o
);
    import ossc_pkg::*;

    // counter just wide enough to reach the hold width
    localparam int unsigned CNT_W = $clog2(PO_RESET_WIDTH + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PO_RESET_WIDTH);

    logic [CNT_W-1:0] cnt_q;
    logic             rst_n_q;

    // counter restarts on every power-on reset
    // the system reset drops together with po_reset_n and
    // releases one edge after the count hits its end
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cnt_q   <= '0;
            rst_n_q <= 1'b0;
        end else begin
            if (cnt_q == CNT_LAST) begin
                rst_n_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign sys_reset_n_o = rst_n_q;

endmodule

//--- verilog/ossc_pkg.sv
package ossc_pkg;

    // system reset hold after power-on reset release, in clk27 cycles
    localparam int unsigned PO_RESET_WIDTH = 27;

    // default resync led stretch, roughly 0.6 s at 27 MHz
    localparam int unsigned LED_HOLD_DEFAULT = (2 ** 24) - 1;

    // wishbone word address and data widths
    localparam int unsigned WB_ADDR_W = 2;
    localparam int unsigned WB_DATA_W = 32;

    // one colour component
    localparam int unsigned PIX_W = 8;

    // one pixel
    typedef struct packed {
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
    } rgb_t;

    // pixel plus sync and field flags
    typedef struct packed {
        rgb_t pix;
        logic hsync;
        logic vsync;
        logic de;
        logic fid;
    } video_bus_t;

    // i2s audio lines
    typedef struct packed {
        logic bck;
        logic ws;
        logic data;
    } i2s_t;

    // control word, isl_reset_n sits in bit 0
    typedef struct packed {
        logic [27:0] reserved;
        logic        audmux_sel;
        logic        capture_sel;
        logic        hdmirx_reset_n;
        logic        isl_reset_n;
    } sys_ctrl_t;

    // status word, buttons in the two low bits
    typedef struct packed {
        logic [27:0] reserved;
        logic        sys_ready;
        logic        ir_rx;
        logic [1:0]  btn;
    } sys_status_t;

    // wishbone classic request from the master
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    // wishbone classic response to the master
    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    // register map, anything else is unmapped
    typedef enum logic [WB_ADDR_W-1:0] {
        REG_CTRL   = WB_ADDR_W'(0),
        REG_STATUS = WB_ADDR_W'(1)
    } reg_addr_e;

endpackage
